//--- src/chip_mem_consts.svh
// widths are fixed for a 128-bit line and a 32-bit lite port, and only 12 address bits reach the RAM
`ifndef CHIP_MEM_CONSTS_SVH
`define CHIP_MEM_CONSTS_SVH

// physical address and data widths
`define PADDR_WIDTH      32
`define MEM_DAT_WIDTH    128
`define IO_DAT_WIDTH     32

// caller tag, the RAM side adds one source bit on top
`define MEM_TAG_WIDTH    4
`define RAM_TAG_WIDTH    (`MEM_TAG_WIDTH + 1)

// byte strobes per beat
`define MEM_STRB_WIDTH   (`MEM_DAT_WIDTH / 8)
`define IO_STRB_WIDTH    (`IO_DAT_WIDTH / 8)

// 4 KB of RAM, upper address bits alias
`define BRAM_ADDR_WIDTH  12
`define LINE_OFFSET      4
`define BRAM_LINE_WIDTH  (`BRAM_ADDR_WIDTH - `LINE_OFFSET)

`endif

//--- src/chip_mem_pkg.sv
// single-beat channel payloads only, burst and AXI side-band fields do not exist here
`include "chip_mem_consts.svh"

package chip_mem_pkg;

   // cached-memory port
   typedef struct packed {
      logic [`PADDR_WIDTH-1:0]    addr;
      logic                       wr;
      logic [`MEM_DAT_WIDTH-1:0]  data;
      logic [`MEM_STRB_WIDTH-1:0] strb;
      logic [`MEM_TAG_WIDTH-1:0]  tag;
   } mem_req_t;

   typedef struct packed {
      logic [`MEM_DAT_WIDTH-1:0]  data;
      logic                       wr;
      logic [`MEM_TAG_WIDTH-1:0]  tag;
   } mem_resp_t;

   // io-lite port
   typedef struct packed {
      logic [`PADDR_WIDTH-1:0]    addr;
      logic                       wr;
      logic [`IO_DAT_WIDTH-1:0]   data;
      logic [`IO_STRB_WIDTH-1:0]  strb;
      logic [`MEM_TAG_WIDTH-1:0]  tag;
   } lite_req_t;

   typedef struct packed {
      logic [`IO_DAT_WIDTH-1:0]   data;
      logic                       wr;
      logic [`MEM_TAG_WIDTH-1:0]  tag;
   } lite_resp_t;

   // after the combiner, tag msb is the source (1 = io)
   typedef struct packed {
      logic [`PADDR_WIDTH-1:0]    addr;
      logic                       wr;
      logic [`MEM_DAT_WIDTH-1:0]  data;
      logic [`MEM_STRB_WIDTH-1:0] strb;
      logic [`RAM_TAG_WIDTH-1:0]  tag;
   } ram_req_t;

   typedef struct packed {
      logic [`MEM_DAT_WIDTH-1:0]  data;
      logic                       wr;
      logic [`RAM_TAG_WIDTH-1:0]  tag;
   } ram_resp_t;

endpackage

//--- src/block_ram.sv
// no reset and no preload, contents are undefined until written
`timescale 1ns/1ps
`include "chip_mem_consts.svh"

module block_ram (
   input  logic                        mig_clk,
   input  logic                        en_i,
   input  logic [`MEM_STRB_WIDTH-1:0]  we_i,
   input  logic [`BRAM_LINE_WIDTH-1:0] addr_i,
   input  logic [`MEM_DAT_WIDTH-1:0]   wrdata_i,
   output logic [`MEM_DAT_WIDTH-1:0]   rddata_o
);

   localparam int LINES = 1 << `BRAM_LINE_WIDTH;

   logic [`MEM_DAT_WIDTH-1:0]   mem [LINES];
   logic [`BRAM_LINE_WIDTH-1:0] addr_q;

   always_ff @(posedge mig_clk) begin
      if (en_i) begin
         addr_q <= addr_i;
         // byte lanes
         for (int i = 0; i < `MEM_STRB_WIDTH; i++) begin
            if (we_i[i]) begin
               mem[addr_i][i*8 +: 8] <= wrdata_i[i*8 +: 8];
            end
         end
      end
   end

   // read of the registered address
   assign rddata_o = mem[addr_q];

endmodule

//--- src/chan_slice.sv
// in_ready_o is registered, so a producer sees one extra entry taken after the output stalls
`timescale 1ns/1ps

module chan_slice #(
   parameter type payload_t = logic
) (
   input  logic     mig_clk,
   input  logic     rst_i,
   input  payload_t in_i,
   input  logic     in_valid_i,
   output logic     in_ready_o,
   output payload_t out_o,
   output logic     out_valid_o,
   input  logic     out_ready_i
);

   payload_t main_q, skid_q;
   logic     main_valid_q, skid_valid_q;
   logic     in_acc;
   logic     out_stall;

   assign in_ready_o  = !skid_valid_q;
   assign in_acc      = in_valid_i && in_ready_o;
   assign out_stall   = main_valid_q && !out_ready_i;
   assign out_o       = main_q;
   assign out_valid_o = main_valid_q;

   always_ff @(posedge mig_clk) begin
      if (rst_i) begin
         main_valid_q <= 1'b0;
         skid_valid_q <= 1'b0;
      end else if (out_stall) begin
         // main is stuck, park the newcomer
         if (in_acc) begin
            skid_valid_q <= 1'b1;
         end
      end else if (skid_valid_q) begin
         main_valid_q <= 1'b1;
         skid_valid_q <= 1'b0;
      end else begin
         main_valid_q <= in_acc;
      end
   end

   always_ff @(posedge mig_clk) begin
      if (in_acc && out_stall) begin
         skid_q <= in_i;
      end
      if (!out_stall) begin
         main_q <= skid_valid_q ? skid_q : in_i;
      end
   end

   a_out_stable: assert property (@(posedge mig_clk) disable iff (rst_i)
      out_stall |=> out_valid_o && $stable(out_o));

endmodule

//--- src/bram_ctrl.sv
// one request per cycle while the response path drains, and address bits above 11 are ignored
`timescale 1ns/1ps
`include "chip_mem_consts.svh"

module bram_ctrl import chip_mem_pkg::*; (
   input  logic      mig_clk,
   input  logic      rst_i,

   input  ram_req_t  req_i,
   input  logic      req_valid_i,
   output logic      req_ready_o,

   output ram_resp_t resp_o,
   output logic      resp_valid_o,
   input  logic      resp_ready_i
);

   logic                        req_acc;
   logic                        ram_en;
   logic [`MEM_STRB_WIDTH-1:0]  ram_we;
   logic [`BRAM_LINE_WIDTH-1:0] ram_addr;
   logic [`MEM_DAT_WIDTH-1:0]   ram_rddata;
   logic                        resp_valid_q;
   logic                        wr_q;
   logic [`RAM_TAG_WIDTH-1:0]   tag_q;

   // stall while a response is waiting to be taken
   assign req_ready_o = !resp_valid_q || resp_ready_i;
   assign req_acc     = req_valid_i && req_ready_o;

   assign ram_en   = req_acc;
   assign ram_we   = (req_acc && req_i.wr) ? req_i.strb : '0;
   assign ram_addr = req_i.addr[`BRAM_ADDR_WIDTH-1:`LINE_OFFSET];

   block_ram ram (
      .mig_clk  ( mig_clk    ),
      .en_i     ( ram_en     ),
      .we_i     ( ram_we     ),
      .addr_i   ( ram_addr   ),
      .wrdata_i ( req_i.data ),
      .rddata_o ( ram_rddata )
   );

   always_ff @(posedge mig_clk) begin
      if (rst_i) begin
         resp_valid_q <= 1'b0;
      end else if (req_acc) begin
         resp_valid_q <= 1'b1;
      end else if (resp_ready_i) begin
         resp_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge mig_clk) begin
      if (req_acc) begin
         wr_q  <= req_i.wr;
         tag_q <= req_i.tag;
      end
   end

   // write responses carry no data
   assign resp_valid_o = resp_valid_q;
   assign resp_o.data  = wr_q ? '0 : ram_rddata;
   assign resp_o.wr    = wr_q;
   assign resp_o.tag   = tag_q;

   a_resp_held: assert property (@(posedge mig_clk) disable iff (rst_i)
      resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o));

endmodule

//--- src/lite_widen_bridge.sv
// one io request in flight at a time, and the lane comes from address bits 3:2 only
`timescale 1ns/1ps
`include "chip_mem_consts.svh"

module lite_widen_bridge import chip_mem_pkg::*; (
   input  logic       mig_clk,
   input  logic       rst_i,

   input  lite_req_t  lite_req_i,
   input  logic       lite_req_valid_i,
   output logic       lite_req_ready_o,
   output lite_resp_t lite_resp_o,
   output logic       lite_resp_valid_o,
   input  logic       lite_resp_ready_i,

   output mem_req_t   full_req_o,
   output logic       full_req_valid_o,
   input  logic       full_req_ready_i,
   input  mem_resp_t  full_resp_i,
   input  logic       full_resp_valid_i,
   output logic       full_resp_ready_o
);

   localparam int LANE_LSB = $clog2(`IO_STRB_WIDTH);
   localparam int LANE_W   = `LINE_OFFSET - LANE_LSB;

   logic              pending_q;
   logic [LANE_W-1:0] lane_q;
   logic [LANE_W-1:0] req_lane;
   logic              req_acc;
   logic              resp_acc;

   assign req_lane = lite_req_i.addr[`LINE_OFFSET-1:LANE_LSB];

   // no new request until the last one has answered
   assign full_req_valid_o = lite_req_valid_i && !pending_q;
   assign lite_req_ready_o = full_req_ready_i && !pending_q;
   assign req_acc          = lite_req_valid_i && lite_req_ready_o;

   always_comb begin
      full_req_o.addr = lite_req_i.addr;
      full_req_o.wr   = lite_req_i.wr;
      full_req_o.data = {{(`MEM_DAT_WIDTH - `IO_DAT_WIDTH){1'b0}}, lite_req_i.data}
                        << (req_lane * `IO_DAT_WIDTH);
      full_req_o.strb = {{(`MEM_STRB_WIDTH - `IO_STRB_WIDTH){1'b0}}, lite_req_i.strb}
                        << (req_lane * `IO_STRB_WIDTH);
      full_req_o.tag  = lite_req_i.tag;
   end

   // narrow the returning line to the recorded lane
   assign lite_resp_valid_o = full_resp_valid_i;
   assign full_resp_ready_o = lite_resp_ready_i;
   assign resp_acc          = full_resp_valid_i && full_resp_ready_o;

   always_comb begin
      lite_resp_o.data = full_resp_i.data[lane_q * `IO_DAT_WIDTH +: `IO_DAT_WIDTH];
      lite_resp_o.wr   = full_resp_i.wr;
      lite_resp_o.tag  = full_resp_i.tag;
   end

   always_ff @(posedge mig_clk) begin
      if (rst_i) begin
         pending_q <= 1'b0;
      end else if (req_acc) begin
         pending_q <= 1'b1;
      end else if (resp_acc) begin
         pending_q <= 1'b0;
      end
   end

   always_ff @(posedge mig_clk) begin
      if (req_acc) begin
         lane_q <= req_lane;
      end
   end

   // an io response without a request behind it means the source bit went astray
   a_resp_pending: assert property (@(posedge mig_clk) disable iff (rst_i)
      full_resp_valid_i |-> pending_q);

endmodule

//--- src/mem_io_combiner.sv
// two sources only, and the source bit sits just above the caller tag
`timescale 1ns/1ps
`include "chip_mem_consts.svh"

module mem_io_combiner import chip_mem_pkg::*; (
   input  logic      mig_clk,
   input  logic      rst_i,

   input  mem_req_t  src0_req_i,
   input  logic      src0_req_valid_i,
   output logic      src0_req_ready_o,
   input  mem_req_t  src1_req_i,
   input  logic      src1_req_valid_i,
   output logic      src1_req_ready_o,

   output ram_req_t  ram_req_o,
   output logic      ram_req_valid_o,
   input  logic      ram_req_ready_i,
   input  ram_resp_t ram_resp_i,
   input  logic      ram_resp_valid_i,
   output logic      ram_resp_ready_o,

   output mem_resp_t src0_resp_o,
   output logic      src0_resp_valid_o,
   input  logic      src0_resp_ready_i,
   output mem_resp_t src1_resp_o,
   output logic      src1_resp_valid_o,
   input  logic      src1_resp_ready_i
);

   logic      last_q;
   logic      grant0, grant1;
   mem_req_t  sel_req;
   logic      resp_src;
   mem_resp_t resp_stripped;

   // last winner yields when both wait
   assign grant0 = src0_req_valid_i && (!src1_req_valid_i || last_q);
   assign grant1 = src1_req_valid_i && (!src0_req_valid_i || !last_q);

   assign sel_req          = grant1 ? src1_req_i : src0_req_i;
   assign ram_req_valid_o  = src0_req_valid_i || src1_req_valid_i;
   assign src0_req_ready_o = grant0 && ram_req_ready_i;
   assign src1_req_ready_o = grant1 && ram_req_ready_i;

   always_comb begin
      ram_req_o.addr = sel_req.addr;
      ram_req_o.wr   = sel_req.wr;
      ram_req_o.data = sel_req.data;
      ram_req_o.strb = sel_req.strb;
      ram_req_o.tag  = {grant1, sel_req.tag};
   end

   always_ff @(posedge mig_clk) begin
      if (rst_i) begin
         last_q <= 1'b1;
      end else if (ram_req_valid_o && ram_req_ready_i) begin
         last_q <= grant1;
      end
   end

   // responses go back by source bit
   assign resp_src          = ram_resp_i.tag[`MEM_TAG_WIDTH];
   assign src0_resp_valid_o = ram_resp_valid_i && !resp_src;
   assign src1_resp_valid_o = ram_resp_valid_i && resp_src;
   assign ram_resp_ready_o  = resp_src ? src1_resp_ready_i : src0_resp_ready_i;

   always_comb begin
      resp_stripped.data = ram_resp_i.data;
      resp_stripped.wr   = ram_resp_i.wr;
      resp_stripped.tag  = ram_resp_i.tag[`MEM_TAG_WIDTH-1:0];
   end

   assign src0_resp_o = resp_stripped;
   assign src1_resp_o = resp_stripped;

   a_one_accept: assert property (@(posedge mig_clk) disable iff (rst_i)
      !(src0_req_valid_i && src0_req_ready_o && src1_req_valid_i && src1_req_ready_o));

endmodule

//--- src/chip_mem_top.sv
// a stalled response on either port also stalls the shared response slice and the RAM behind it
`timescale 1ns/1ps

module chip_mem_top import chip_mem_pkg::*; (
   input  logic       mig_clk,
   input  logic       rst_i,

   input  mem_req_t   mem_req_i,
   input  logic       mem_req_valid_i,
   output logic       mem_req_ready_o,
   output mem_resp_t  mem_resp_o,
   output logic       mem_resp_valid_o,
   input  logic       mem_resp_ready_i,

   input  lite_req_t  io_req_i,
   input  logic       io_req_valid_i,
   output logic       io_req_ready_o,
   output lite_resp_t io_resp_o,
   output logic       io_resp_valid_o,
   input  logic       io_resp_ready_i
);

   // io requests widened to full lines
   mem_req_t  io_full_req;
   logic      io_full_req_valid, io_full_req_ready;
   mem_resp_t io_full_resp;
   logic      io_full_resp_valid, io_full_resp_ready;

   // combined path to and from the RAM
   ram_req_t  comb_req, ctrl_req;
   logic      comb_req_valid, comb_req_ready, ctrl_req_valid, ctrl_req_ready;
   ram_resp_t ctrl_resp, comb_resp;
   logic      ctrl_resp_valid, ctrl_resp_ready, comb_resp_valid, comb_resp_ready;

   lite_widen_bridge io_bridge (
      .mig_clk           ( mig_clk            ),
      .rst_i             ( rst_i              ),
      .lite_req_i        ( io_req_i           ),
      .lite_req_valid_i  ( io_req_valid_i     ),
      .lite_req_ready_o  ( io_req_ready_o     ),
      .lite_resp_o       ( io_resp_o          ),
      .lite_resp_valid_o ( io_resp_valid_o    ),
      .lite_resp_ready_i ( io_resp_ready_i    ),
      .full_req_o        ( io_full_req        ),
      .full_req_valid_o  ( io_full_req_valid  ),
      .full_req_ready_i  ( io_full_req_ready  ),
      .full_resp_i       ( io_full_resp       ),
      .full_resp_valid_i ( io_full_resp_valid ),
      .full_resp_ready_o ( io_full_resp_ready )
   );

   mem_io_combiner combiner (
      .mig_clk           ( mig_clk            ),
      .rst_i             ( rst_i              ),
      .src0_req_i        ( mem_req_i          ),
      .src0_req_valid_i  ( mem_req_valid_i    ),
      .src0_req_ready_o  ( mem_req_ready_o    ),
      .src1_req_i        ( io_full_req        ),
      .src1_req_valid_i  ( io_full_req_valid  ),
      .src1_req_ready_o  ( io_full_req_ready  ),
      .ram_req_o         ( comb_req           ),
      .ram_req_valid_o   ( comb_req_valid     ),
      .ram_req_ready_i   ( comb_req_ready     ),
      .ram_resp_i        ( comb_resp          ),
      .ram_resp_valid_i  ( comb_resp_valid    ),
      .ram_resp_ready_o  ( comb_resp_ready    ),
      .src0_resp_o       ( mem_resp_o         ),
      .src0_resp_valid_o ( mem_resp_valid_o   ),
      .src0_resp_ready_i ( mem_resp_ready_i   ),
      .src1_resp_o       ( io_full_resp       ),
      .src1_resp_valid_o ( io_full_resp_valid ),
      .src1_resp_ready_i ( io_full_resp_ready )
   );

   chan_slice #(.payload_t(ram_req_t)) req_slice (
      .mig_clk     ( mig_clk        ),
      .rst_i       ( rst_i          ),
      .in_i        ( comb_req       ),
      .in_valid_i  ( comb_req_valid ),
      .in_ready_o  ( comb_req_ready ),
      .out_o       ( ctrl_req       ),
      .out_valid_o ( ctrl_req_valid ),
      .out_ready_i ( ctrl_req_ready )
   );

   bram_ctrl ram_ctrl (
      .mig_clk      ( mig_clk         ),
      .rst_i        ( rst_i           ),
      .req_i        ( ctrl_req        ),
      .req_valid_i  ( ctrl_req_valid  ),
      .req_ready_o  ( ctrl_req_ready  ),
      .resp_o       ( ctrl_resp       ),
      .resp_valid_o ( ctrl_resp_valid ),
      .resp_ready_i ( ctrl_resp_ready )
   );

   chan_slice #(.payload_t(ram_resp_t)) resp_slice (
      .mig_clk     ( mig_clk         ),
      .rst_i       ( rst_i           ),
      .in_i        ( ctrl_resp       ),
      .in_valid_i  ( ctrl_resp_valid ),
      .in_ready_o  ( ctrl_resp_ready ),
      .out_o       ( comb_resp       ),
      .out_valid_o ( comb_resp_valid ),
      .out_ready_i ( comb_resp_ready )
   );

endmodule

//--- dv/tb_chip_mem.sv
// the RAM has no reset or preload, so every line is written through the memory port before any read
`timescale 1ns/1ps
`include "chip_mem_consts.svh"

module tb_chip_mem import chip_mem_pkg::*; ();

   localparam int RAM_BYTES   = 1 << `BRAM_ADDR_WIDTH;
   localparam int LINES       = RAM_BYTES / `MEM_STRB_WIDTH;
   localparam int N_FULL      = 8;
   localparam int N_PART      = 6;
   localparam int N_RAND      = 150;
   localparam int TOTAL_REQS  = LINES + 2 * N_FULL + 2 * N_PART + 9 + 2 * N_RAND;
   localparam int CYCLE_LIMIT = 20 * TOTAL_REQS + 200;

   logic       mig_clk;
   logic       rst_i;
   mem_req_t   mem_req;
   logic       mem_req_valid, mem_req_ready;
   mem_resp_t  mem_resp;
   logic       mem_resp_valid, mem_resp_ready;
   lite_req_t  io_req;
   logic       io_req_valid, io_req_ready;
   lite_resp_t io_resp;
   logic       io_resp_valid, io_resp_ready;

   logic [7:0]  ref_mem [RAM_BYTES];
   mem_resp_t   exp_mem_q[$];
   lite_resp_t  exp_io_q[$];
   mem_resp_t   mem_head;
   lite_resp_t  io_head;
   logic        bp_on;
   int          cycle_cnt = 0;
   logic [31:0] test_addr [N_FULL];

   chip_mem_top dut0 (
      .mig_clk          ( mig_clk        ),
      .rst_i            ( rst_i          ),
      .mem_req_i        ( mem_req        ),
      .mem_req_valid_i  ( mem_req_valid  ),
      .mem_req_ready_o  ( mem_req_ready  ),
      .mem_resp_o       ( mem_resp       ),
      .mem_resp_valid_o ( mem_resp_valid ),
      .mem_resp_ready_i ( mem_resp_ready ),
      .io_req_i         ( io_req         ),
      .io_req_valid_i   ( io_req_valid   ),
      .io_req_ready_o   ( io_req_ready   ),
      .io_resp_o        ( io_resp        ),
      .io_resp_valid_o  ( io_resp_valid  ),
      .io_resp_ready_i  ( io_resp_ready  )
   );

   initial begin
      mig_clk = 1'b0;
      forever #4 mig_clk = ~mig_clk;
   end

   task automatic report_failure(input string line);
      $display("%s", line);
      $display("Checks failed");
      $fatal(1);
   endtask

   // line from the byte model with aliased upper address bits
   function automatic logic [127:0] ref_read_line(input logic [31:0] addr);
      logic [127:0] line;
      int           base;
      base = int'(addr[`BRAM_ADDR_WIDTH-1:4]) * 16;
      for (int i = 0; i < 16; i++) begin
         line[i*8 +: 8] = ref_mem[base + i];
      end
      return line;
   endfunction

   task automatic ref_write(input int base, input int n, input logic [127:0] data,
                            input logic [15:0] strb);
      for (int i = 0; i < n; i++) begin
         if (strb[i]) begin
            ref_mem[base + i] = data[i*8 +: 8];
         end
      end
   endtask

   // each word holds its own byte address
   function automatic logic [127:0] fill_line(input int line);
      logic [127:0] val;
      logic [11:0]  a;
      for (int w = 0; w < 4; w++) begin
         a = 12'(line * 16 + w * 4);
         val[w*32 +: 32] = {8'ha5, a, ~a};
      end
      return val;
   endfunction

   task automatic check_mem_resp(input mem_resp_t got, input mem_resp_t exp);
      if (got !== exp) begin
         report_failure($sformatf(
            "mismatch at %0t: mem resp tag %h wr %b data %h, expected %h %b %h",
            $time, got.tag, got.wr, got.data, exp.tag, exp.wr, exp.data));
      end
   endtask

   task automatic check_lite_resp(input lite_resp_t got, input lite_resp_t exp);
      if (got !== exp) begin
         report_failure($sformatf(
            "mismatch at %0t: io resp tag %h wr %b data %h, expected %h %b %h",
            $time, got.tag, got.wr, got.data, exp.tag, exp.wr, exp.data));
      end
   endtask

   // expected responses are fixed in acceptance order
   always @(posedge mig_clk) begin
      mem_resp_t    me;
      lite_resp_t   le;
      logic [127:0] line;
      int           lane;
      if (!rst_i && mem_req_valid && mem_req_ready === 1'b1) begin
         line    = ref_read_line(mem_req.addr);
         me.data = mem_req.wr ? '0 : line;
         me.wr   = mem_req.wr;
         me.tag  = mem_req.tag;
         exp_mem_q.push_back(me);
         if (mem_req.wr) begin
            ref_write(int'(mem_req.addr[`BRAM_ADDR_WIDTH-1:4]) * 16, 16,
                      mem_req.data, mem_req.strb);
         end
      end
      if (!rst_i && io_req_valid && io_req_ready === 1'b1) begin
         line    = ref_read_line(io_req.addr);
         lane    = int'(io_req.addr[3:2]);
         le.data = io_req.wr ? '0 : line[lane*32 +: 32];
         le.wr   = io_req.wr;
         le.tag  = io_req.tag;
         exp_io_q.push_back(le);
         if (io_req.wr) begin
            ref_write(int'(io_req.addr[`BRAM_ADDR_WIDTH-1:4]) * 16 + lane * 4, 4,
                      128'(io_req.data), 16'(io_req.strb));
         end
      end
   end

   always @(posedge mig_clk) begin
      if (!rst_i && mem_resp_valid === 1'b1 && mem_resp_ready) begin
         if (exp_mem_q.size() == 0) begin
            report_failure("memory port returned a response that no request asked for");
         end else begin
            mem_head = exp_mem_q.pop_front();
            check_mem_resp(mem_resp, mem_head);
         end
      end
   end

   always @(posedge mig_clk) begin
      if (!rst_i && io_resp_valid === 1'b1 && io_resp_ready) begin
         if (exp_io_q.size() == 0) begin
            report_failure("IO port returned a response that no request asked for");
         end else begin
            io_head = exp_io_q.pop_front();
            check_lite_resp(io_resp, io_head);
         end
      end
   end

   always @(posedge mig_clk) begin
      cycle_cnt++;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         report_failure($sformatf("timeout after %0d cycles, the DUT stopped answering",
                                  cycle_cnt));
      end
   end

   // random response back-pressure
   always @(negedge mig_clk) begin
      if (bp_on) begin
         mem_resp_ready = ($urandom % 4) != 0;
         io_resp_ready  = ($urandom % 4) != 0;
      end else begin
         mem_resp_ready = 1'b1;
         io_resp_ready  = 1'b1;
      end
   end

   // valid stays up after acceptance until the next send or idle
   task automatic mem_send(input logic [31:0] addr, input logic wr, input logic [127:0] data,
                           input logic [15:0] strb, input logic [3:0] tag);
      @(negedge mig_clk);
      mem_req.addr  = addr;
      mem_req.wr    = wr;
      mem_req.data  = data;
      mem_req.strb  = strb;
      mem_req.tag   = tag;
      mem_req_valid = 1'b1;
      do @(posedge mig_clk); while (mem_req_ready !== 1'b1);
   endtask

   task automatic mem_idle();
      @(negedge mig_clk);
      mem_req_valid = 1'b0;
   endtask

   task automatic io_send(input logic [31:0] addr, input logic wr, input logic [31:0] data,
                          input logic [3:0] strb, input logic [3:0] tag);
      @(negedge mig_clk);
      io_req.addr  = addr;
      io_req.wr    = wr;
      io_req.data  = data;
      io_req.strb  = strb;
      io_req.tag   = tag;
      io_req_valid = 1'b1;
      do @(posedge mig_clk); while (io_req_ready !== 1'b1);
   endtask

   task automatic io_idle();
      @(negedge mig_clk);
      io_req_valid = 1'b0;
   endtask

   task automatic wait_for_drain();
      while (exp_mem_q.size() != 0 || exp_io_q.size() != 0) begin
         @(posedge mig_clk);
      end
   endtask

   task automatic mem_random_traffic();
      repeat (N_RAND) begin
         mem_send($urandom, 1'($urandom), {$urandom, $urandom, $urandom, $urandom},
                  16'($urandom), 4'($urandom));
         if ($urandom % 4 == 0) begin
            mem_idle();
         end
      end
      mem_idle();
   endtask

   task automatic io_random_traffic();
      repeat (N_RAND) begin
         io_send($urandom, 1'($urandom), $urandom, 4'($urandom), 4'($urandom));
         if ($urandom % 4 == 0) begin
            io_idle();
         end
      end
      io_idle();
   endtask

   initial begin
      void'($urandom(32'hb0e1));
      rst_i          = 1'b1;
      mem_req        = '0;
      mem_req_valid  = 1'b0;
      mem_resp_ready = 1'b1;
      io_req         = '0;
      io_req_valid   = 1'b0;
      io_resp_ready  = 1'b1;
      bp_on          = 1'b0;
      repeat (10) @(posedge mig_clk);
      @(negedge mig_clk);
      rst_i = 1'b0;

      // quiet after reset
      repeat (20) begin
         @(posedge mig_clk);
         if (mem_resp_valid !== 1'b0 || io_resp_valid !== 1'b0) begin
            report_failure("a response valid rose after reset with no request issued");
         end
      end

      for (int l = 0; l < LINES; l++) begin
         mem_send(32'(l * 16), 1'b1, fill_line(l), 16'hffff, 4'(l));
      end
      mem_idle();
      wait_for_drain();

      // full lines read back through an aliased address
      for (int i = 0; i < N_FULL; i++) begin
         test_addr[i] = 32'((i * 37 % LINES) * 16);
         mem_send(test_addr[i], 1'b1, {$urandom, $urandom, $urandom, $urandom}, 16'hffff, 4'(i));
      end
      for (int i = 0; i < N_FULL; i++) begin
         mem_send(test_addr[i] | 32'h8000_0000, 1'b0, '0, '0, 4'(i + 8));
      end
      mem_idle();
      wait_for_drain();

      // partial strobes
      for (int i = 0; i < N_PART; i++) begin
         test_addr[i] = 32'(($urandom % LINES) * 16);
         mem_send(test_addr[i], 1'b1, {$urandom, $urandom, $urandom, $urandom},
                  16'($urandom), 4'(i));
      end
      for (int i = 0; i < N_PART; i++) begin
         mem_send(test_addr[i], 1'b0, '0, '0, 4'(i + 6));
      end
      mem_idle();
      wait_for_drain();

      // io lanes seen from both ports
      for (int lane = 0; lane < 4; lane++) begin
         io_send(32'h5a0 + 32'(lane * 4), 1'b1, 32'hc0de_0000 | 32'(lane),
                 (lane == 2) ? 4'b0101 : 4'hf, 4'(lane));
      end
      io_idle();
      mem_send(32'h0001_05a0, 1'b0, '0, '0, 4'h9);
      mem_idle();
      for (int lane = 0; lane < 4; lane++) begin
         io_send(32'h5a0 + 32'(lane * 4), 1'b0, '0, '0, 4'(lane + 4));
      end
      io_idle();
      wait_for_drain();

      bp_on = 1'b1;
      fork
         mem_random_traffic();
         io_random_traffic();
      join
      wait_for_drain();
      bp_on = 1'b0;

      // a few idle cycles so a stray response still reaches the compare processes
      repeat (5) @(posedge mig_clk);
      $display("All checks passed");
      $finish;
   end

endmodule

//--- tb.f
+incdir+src
src/chip_mem_pkg.sv
src/block_ram.sv
src/chan_slice.sv
src/bram_ctrl.sv
src/lite_widen_bridge.sv
src/mem_io_combiner.sv
src/chip_mem_top.sv
dv/tb_chip_mem.sv

//--- Bender.yml
package:
  name: chip_mem

sources:
  - include_dirs:
      - src
    files:
      - src/chip_mem_pkg.sv
      - src/block_ram.sv
      - src/chan_slice.sv
      - src/bram_ctrl.sv
      - src/lite_widen_bridge.sv
      - src/mem_io_combiner.sv
      - src/chip_mem_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/tb_chip_mem.sv
